// File: hw/boot_pkg.sv
package boot_pkg;

  // widths of the load path
  localparam int unsigned BYTE_W  = 8;
  localparam int unsigned WORD_W  = 32;
  localparam int unsigned IADDR_W = 10;
  localparam int unsigned BAUD_W  = 16;

  typedef logic [BYTE_W-1:0]  byte_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [IADDR_W-1:0] iaddr_t;
  typedef logic [BAUD_W-1:0]  baud_div_t;

  // instruction memory size in words
  localparam int unsigned IMEM_DEPTH = 1024;

  // marker word closing a program load, never stored
  localparam word_t END_OF_PROG = 32'h0000_0FFF;

  typedef enum logic [1:0] {
    CTRL_IDLE = 2'd0,
    CTRL_LOAD = 2'd1,
    CTRL_DONE = 2'd2
  } ctrl_state_e;

  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

endpackage

// File: hw/uart_rx_prog.sv
module uart_rx_prog (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                rx_i,
  input  boot_pkg::baud_div_t clks_per_bit_i,
  output logic                rx_dv_o,
  output boot_pkg::byte_t     rx_byte_o
);

  boot_pkg::rx_state_e state_q;
  boot_pkg::baud_div_t cnt_q;
  boot_pkg::baud_div_t half_bit;
  logic [2:0]          bit_idx_q;

  logic rx_meta_q;
  logic rx_sync_q;
  logic rx_prev_q;

  logic start_edge;
  logic half_end;
  logic bit_end;

  // two flop synchronizer plus one flop for edge detection
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  assign start_edge = rx_prev_q & ~rx_sync_q;

  // half a bit period to reach the middle of the start bit
  assign half_bit = clks_per_bit_i >> 1;
  assign half_end = (cnt_q == half_bit - 1'b1);
  assign bit_end  = (cnt_q == clks_per_bit_i - 1'b1);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= boot_pkg::RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      rx_dv_o   <= 1'b0;
    end else begin
      rx_dv_o <= 1'b0;
      case (state_q)
        boot_pkg::RX_IDLE: begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          if (start_edge) begin
            state_q <= boot_pkg::RX_START;
          end
        end

        boot_pkg::RX_START: begin
          if (half_end) begin
            cnt_q <= '0;
            // line back high at mid start bit means a glitch
            if (!rx_sync_q) begin
              state_q <= boot_pkg::RX_DATA;
            end else begin
              state_q <= boot_pkg::RX_IDLE;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end

        boot_pkg::RX_DATA: begin
          if (bit_end) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= boot_pkg::RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end

        boot_pkg::RX_STOP: begin
          if (bit_end) begin
            cnt_q <= '0;
            // frame error drops the byte silently
            rx_dv_o <= rx_sync_q;
            state_q <= boot_pkg::RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end

        default: begin
          state_q <= boot_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk_i) begin
    if ((state_q == boot_pkg::RX_DATA) && bit_end) begin
      rx_byte_o <= {rx_sync_q, rx_byte_o[7:1]};
    end
  end

endmodule

// File: hw/iccm_controller.sv
module iccm_controller (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             prog_i,
  input  logic             rx_dv_i,
  input  boot_pkg::byte_t  rx_byte_i,
  output logic             we_o,
  output boot_pkg::iaddr_t addr_o,
  output boot_pkg::word_t  wdata_o,
  output logic             prog_rst_n_o
);

  boot_pkg::ctrl_state_e state_q;
  logic [1:0]            byte_cnt_q;
  boot_pkg::word_t       word_q;
  boot_pkg::word_t       next_word;
  logic                  byte_take;
  logic                  word_done;

  // first byte ends up in the low bits after four shifts
  assign next_word = {rx_byte_i, word_q[31:8]};

  assign byte_take = (state_q == boot_pkg::CTRL_LOAD) && rx_dv_i;
  assign word_done = byte_take && (byte_cnt_q == 2'd3);

  // word register holds the finished word while we_o is high
  assign wdata_o = word_q;

  // core held in reset for the whole load
  assign prog_rst_n_o = (state_q != boot_pkg::CTRL_LOAD);

  always_ff @(posedge clk_i) begin
    if (byte_take) begin
      word_q <= next_word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= boot_pkg::CTRL_IDLE;
      byte_cnt_q <= '0;
      addr_o     <= '0;
      we_o       <= 1'b0;
    end else begin
      we_o <= 1'b0;

      // advance once the write has gone out
      if (we_o) begin
        addr_o <= addr_o + 1'b1;
      end

      case (state_q)
        boot_pkg::CTRL_IDLE,
        boot_pkg::CTRL_DONE: begin
          // prog_i still high here starts a fresh load
          if (prog_i) begin
            state_q    <= boot_pkg::CTRL_LOAD;
            byte_cnt_q <= '0;
            addr_o     <= '0;
          end
        end

        boot_pkg::CTRL_LOAD: begin
          if (rx_dv_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
          if (word_done) begin
            if (next_word == boot_pkg::END_OF_PROG) begin
              state_q <= boot_pkg::CTRL_DONE;
            end else begin
              we_o <= 1'b1;
            end
          end
        end

        default: begin
          state_q <= boot_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hw/instr_mem.sv
module instr_mem (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             we_i,
  input  boot_pkg::iaddr_t waddr_i,
  input  boot_pkg::word_t  wdata_i,
  input  logic             rd_en_i,
  input  boot_pkg::iaddr_t rd_addr_i,
  output boot_pkg::word_t  rd_data_o
);

  boot_pkg::word_t mem [boot_pkg::IMEM_DEPTH];

  // whole word writes only
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read, holds last word when not enabled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_data_o <= '0;
    end else if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

// File: hw/boot_top.sv
module boot_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                prog_i,
  input  boot_pkg::baud_div_t clks_per_bit_i,
  input  logic                uart_rx_i,
  input  logic                rd_en_i,
  input  boot_pkg::iaddr_t    rd_addr_i,
  output boot_pkg::word_t     rd_data_o,
  output logic                prog_rst_n_o
);

  // receiver to controller
  logic            rx_dv;
  boot_pkg::byte_t rx_byte;

  // controller to memory
  logic             we;
  boot_pkg::iaddr_t waddr;
  boot_pkg::word_t  wdata;

  uart_rx_prog u_uart_rx_prog (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rx_i           (uart_rx_i),
    .clks_per_bit_i (clks_per_bit_i),
    .rx_dv_o        (rx_dv),
    .rx_byte_o      (rx_byte)
  );

  iccm_controller u_iccm_controller (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .prog_i       (prog_i),
    .rx_dv_i      (rx_dv),
    .rx_byte_i    (rx_byte),
    .we_o         (we),
    .addr_o       (waddr),
    .wdata_o      (wdata),
    .prog_rst_n_o (prog_rst_n_o)
  );

  // read port stands in for the core fetch bus
  instr_mem u_instr_mem (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .we_i      (we),
    .waddr_i   (waddr),
    .wdata_i   (wdata),
    .rd_en_i   (rd_en_i),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o)
  );

endmodule

// File: sim/boot_props.sv
module boot_props (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  prog_i,
  input logic                  rx_dv_i,
  input logic                  we_i,
  input boot_pkg::iaddr_t      waddr_i,
  input boot_pkg::ctrl_state_e ctrl_state_i,
  input logic                  prog_rst_n_i,
  input boot_pkg::word_t       rd_data_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // failing assertions so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // first edge out of reset sees every output quiet
  quiet_after_reset: assert property (
    @(posedge clk_i) $rose(rst_n_i) |->
      (!rx_dv_i && !we_i && prog_rst_n_i && (rd_data_i == '0) &&
       (ctrl_state_i == boot_pkg::CTRL_IDLE))
  ) else begin
    $error("outputs not quiet on the first edge after reset");
    fail_cnt++;
  end

  // core reset drops on the edge after a load request
  core_reset_on_request: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (prog_i && prog_rst_n_i) |=> !prog_rst_n_i
  ) else begin
    $error("prog_rst_n_o still high the cycle after a load request");
    fail_cnt++;
  end

  write_only_in_load: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> (ctrl_state_i == boot_pkg::CTRL_LOAD)
  ) else begin
    $error("memory write outside a load");
    fail_cnt++;
  end

  // consecutive words go to consecutive addresses
  addr_step_after_write: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    we_i |=> (waddr_i == boot_pkg::iaddr_t'($past(waddr_i) + 1'b1))
  ) else begin
    $error("write address did not advance by one after a write");
    fail_cnt++;
  end

  // the end marker itself is never stored
  no_write_after_marker: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ((ctrl_state_i == boot_pkg::CTRL_DONE) &&
     ($past(ctrl_state_i) == boot_pkg::CTRL_LOAD)) |-> !we_i
  ) else begin
    $error("memory write in the cycle after the end marker");
    fail_cnt++;
  end

  rx_strobe_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rx_dv_i |=> !rx_dv_i
  ) else begin
    $error("receiver strobe longer than one cycle");
    fail_cnt++;
  end

endmodule

bind boot_top boot_props u_boot_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .prog_i       (prog_i),
  .rx_dv_i      (rx_dv),
  .we_i         (we),
  .waddr_i      (waddr),
  .ctrl_state_i (u_iccm_controller.state_q),
  .prog_rst_n_i (prog_rst_n_o),
  .rd_data_i    (rd_data_o)
);

// File: sim/tb_boot_top.sv
module tb_boot_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned LOAD1_WORDS = 12;
  localparam int unsigned LOAD2_WORDS = 5;
  localparam int unsigned LOAD3_WORDS = 4;
  localparam int unsigned IDLE_BYTES  = 8;
  localparam int unsigned READ_WORDS  = 12;
  localparam int unsigned MAX_CPB     = 13;

  // every load also carries the marker, the third one a dropped byte
  localparam int unsigned TOTAL_BYTES = (LOAD1_WORDS + 1) * 4 + (LOAD2_WORDS + 1) * 4 +
                                        (LOAD3_WORDS + 1) * 4 + 1 + IDLE_BYTES;
  localparam int unsigned CYCLE_LIMIT = TOTAL_BYTES * 10 * MAX_CPB + 2000;

  logic                clk_i;
  logic                rst_n_i;
  logic                prog_i;
  boot_pkg::baud_div_t clks_per_bit_i;
  logic                uart_rx_i;
  logic                rd_en_i;
  boot_pkg::iaddr_t    rd_addr_i;
  boot_pkg::word_t     rd_data_o;
  logic                prog_rst_n_o;

  // expected memory contents
  boot_pkg::word_t model_mem [boot_pkg::IMEM_DEPTH];
  boot_pkg::word_t load_words [$];

  int          seed = 32'h6cd707e0;
  int unsigned test_errs = 0;
  int unsigned pass_cnt = 0;
  int unsigned fail_cnt = 0;
  int unsigned prop_fails = 0;
  int unsigned cycle_cnt = 0;

  boot_top u_boot_top (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .prog_i         (prog_i),
    .clks_per_bit_i (clks_per_bit_i),
    .uart_rx_i      (uart_rx_i),
    .rd_en_i        (rd_en_i),
    .rd_addr_i      (rd_addr_i),
    .rd_data_o      (rd_data_o),
    .prog_rst_n_o   (prog_rst_n_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic boot_pkg::word_t random_word();
    boot_pkg::word_t w;
    w = $random(seed);
    // a random marker would end the load early
    if (w == boot_pkg::END_OF_PROG) begin
      w = ~w;
    end
    return w;
  endfunction

  // one bit on the line, called on a rising edge
  task automatic drive_bit(input logic b);
    uart_rx_i <= b;
    repeat (clks_per_bit_i) @(posedge clk_i);
  endtask

  task automatic send_frame(input boot_pkg::byte_t data, input logic stop_bit);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(stop_bit);
    // idle bit so the next start bit has a falling edge
    if (!stop_bit) begin
      drive_bit(1'b1);
    end
  endtask

  task automatic check_core_reset(input logic expected);
    @(negedge clk_i);
    assert (prog_rst_n_o == expected) else begin
      $display("Fail at %0t ns: prog_rst_n_o expected %b actual %b",
               $time, expected, prog_rst_n_o);
      test_errs++;
    end
    @(posedge clk_i);
  endtask

  task automatic check_read(input boot_pkg::iaddr_t addr, input boot_pkg::word_t expected);
    rd_en_i   <= 1'b1;
    rd_addr_i <= addr;
    @(posedge clk_i);
    rd_en_i <= 1'b0;
    @(negedge clk_i);
    assert (rd_data_o == expected) else begin
      $display("Fail at %0t ns: rd_data_o at address %0d expected %h actual %h",
               $time, addr, expected, rd_data_o);
      test_errs++;
    end
    @(posedge clk_i);
  endtask

  task automatic read_back(input int unsigned count);
    for (int unsigned a = 0; a < count; a++) begin
      check_read(boot_pkg::iaddr_t'(a), model_mem[a]);
    end
  endtask

  task automatic fill_words(input int unsigned count);
    load_words.delete();
    repeat (count) load_words.push_back(random_word());
  endtask

  // whole load of load_words plus marker, a bad stop frame goes before byte drop_at
  task automatic run_load(input boot_pkg::baud_div_t cpb, input int drop_at);
    boot_pkg::byte_t stream [$];
    boot_pkg::word_t w;
    boot_pkg::byte_t junk;
    foreach (load_words[i]) begin
      w = load_words[i];
      for (int b = 0; b < 4; b++) begin
        stream.push_back(w[8*b +: 8]);
      end
    end
    w = boot_pkg::END_OF_PROG;
    for (int b = 0; b < 4; b++) begin
      stream.push_back(w[8*b +: 8]);
    end

    clks_per_bit_i <= cpb;
    prog_i         <= 1'b1;
    do @(negedge clk_i); while (prog_rst_n_o);
    @(posedge clk_i);
    prog_i <= 1'b0;

    foreach (stream[i]) begin
      if (i == drop_at) begin
        junk = $random(seed);
        send_frame(junk, 1'b0);
        check_core_reset(1'b0);
      end
      send_frame(stream[i], 1'b1);
      if (i < stream.size() - 1) begin
        check_core_reset(1'b0);
      end
    end

    do @(negedge clk_i); while (prog_rst_n_o !== 1'b1);
    @(posedge clk_i);
    check_core_reset(1'b1);

    // words land at consecutive addresses from zero
    foreach (load_words[i]) begin
      model_mem[i] = load_words[i];
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %0d %s: ok", num, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", num, name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    rst_n_i        = 1'b0;
    prog_i         = 1'b0;
    clks_per_bit_i = 16'd8;
    uart_rx_i      = 1'b1;
    rd_en_i        = 1'b0;
    rd_addr_i      = '0;

    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    // nothing requested yet
    @(negedge clk_i);
    assert (rd_data_o == '0) else begin
      $display("Fail at %0t ns: rd_data_o expected %h actual %h", $time, 32'h0, rd_data_o);
      test_errs++;
    end
    @(posedge clk_i);
    check_core_reset(1'b1);
    finish_test(1, "after reset");

    fill_words(LOAD1_WORDS);
    run_load(16'd8, -1);
    read_back(READ_WORDS);
    finish_test(2, "load and read back");

    // shorter load leaves the old tail in place
    fill_words(LOAD2_WORDS);
    run_load(16'd13, -1);
    read_back(READ_WORDS);
    finish_test(3, "marker not written");

    fill_words(LOAD3_WORDS);
    run_load(16'd8, 6);
    read_back(READ_WORDS);
    finish_test(4, "frame error");

    clks_per_bit_i <= 16'd8;
    @(posedge clk_i);
    repeat (IDLE_BYTES) begin
      send_frame(boot_pkg::byte_t'($random(seed)), 1'b1);
      check_core_reset(1'b1);
    end
    read_back(READ_WORDS);
    finish_test(5, "bytes while idle");

    prop_fails = u_boot_top.u_boot_props.fail_cnt;
    $display("summary: %0d tests passed, %0d tests failed, %0d property failures",
             pass_cnt, fail_cnt, prop_fails);
    if ((fail_cnt == 0) && (prop_fails == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
hw/boot_pkg.sv
hw/uart_rx_prog.sv
hw/iccm_controller.sv
hw/instr_mem.sv
hw/boot_top.sv
sim/boot_props.sv
sim/tb_boot_top.sv
